//--- all.f
+incdir+verif
common/hdc_pkg.sv
common/axil_map_pkg.sv
common/encode_if.sv
control/axil_ctrl.sv
itemgen/xorshift32.sv
itemgen/item_gen.sv
encoder/hv_core.sv
encoder/stream_ctrl.sv
source/hdc_top.sv
verif/tb_hdc_top.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
    -f all.f --top-module tb_hdc_top -o sim_hdc
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

output=$(./obj_dir/sim_hdc)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "^Simulation PASSED$"; then
    exit 0
fi
exit 1

//--- verif/tb_hdc_model.svh
`ifndef TB_HDC_MODEL_SVH
`define TB_HDC_MODEL_SVH

typedef logic [hdc_pkg::core_num*hdc_pkg::hv_dim-1:0] out_word_t;

int checks;
int errors;
int timeouts;

hdc_pkg::hv_t item_table [hdc_pkg::item_depth];
int           acc        [hdc_pkg::core_num][hdc_pkg::hv_dim];

// xorshift32, shifts 13/17/5
function automatic logic [31:0] xorshift_next(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// low word first, the first word is one step past the seed
function automatic void build_items();
    logic [31:0] w;
    w = hdc_pkg::xs_seed;
    for (int k = 0; k < hdc_pkg::item_depth; k++) begin
        for (int i = 0; i < hdc_pkg::words_per_hv; i++) begin
            w = xorshift_next(w);
            item_table[k][i*hdc_pkg::word_w +: hdc_pkg::word_w] = w;
        end
    end
endfunction

// bit j takes bit (j - rot) mod 64
function automatic hdc_pkg::hv_t rotate_vec(input hdc_pkg::hv_t v, input int rot);
    hdc_pkg::hv_t r;
    for (int j = 0; j < hdc_pkg::hv_dim; j++) begin
        r[j] = v[(j - rot + hdc_pkg::hv_dim) % hdc_pkg::hv_dim];
    end
    return r;
endfunction

function automatic void clear_counts();
    for (int c = 0; c < hdc_pkg::core_num; c++) begin
        for (int j = 0; j < hdc_pkg::hv_dim; j++) begin
            acc[c][j] = 0;
        end
    end
endfunction

// +1 for a set bit, -1 for a clear bit
function automatic void accumulate(input int core, input hdc_pkg::instr_t instr);
    hdc_pkg::hv_t vec;
    vec = rotate_vec(item_table[int'(instr[hdc_pkg::item_addr_w-1:0])],
                     int'(instr[hdc_pkg::rot_lsb +: hdc_pkg::rot_w]));
    for (int j = 0; j < hdc_pkg::hv_dim; j++) begin
        acc[core][j] += vec[j] ? 1 : -1;
    end
endfunction

function automatic out_word_t expected_output();
    out_word_t v;
    for (int c = 0; c < hdc_pkg::core_num; c++) begin
        for (int j = 0; j < hdc_pkg::hv_dim; j++) begin
            v[c*hdc_pkg::hv_dim + j] = (acc[c][j] > 0);
        end
    end
    return v;
endfunction

task automatic check_value(input string name, input out_word_t got, input out_word_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
    end
endtask

task automatic note_timeout(input string what);
    timeouts++;
    $display("timed out while waiting for %s", what);
endtask

`endif

//--- verif/tb_hdc_top.sv
`timescale 1ns/1ps

module tb_hdc_top;

    localparam int wait_limit = 200;

    logic        AXIS_ACLK;
    logic        S_AXI_ARESETN;
    logic [31:0] S_AXI_AWADDR;
    logic        S_AXI_AWVALID;
    logic        S_AXI_AWREADY;
    logic [31:0] S_AXI_WDATA;
    logic        S_AXI_WVALID;
    logic        S_AXI_WREADY;
    logic [1:0]  S_AXI_BRESP;
    logic        S_AXI_BVALID;
    logic        S_AXI_BREADY;
    logic [31:0] S_AXI_ARADDR;
    logic        S_AXI_ARVALID;
    logic        S_AXI_ARREADY;
    logic [31:0] S_AXI_RDATA;
    logic [1:0]  S_AXI_RRESP;
    logic        S_AXI_RVALID;
    logic        S_AXI_RREADY;
    logic [31:0] S_AXIS_TDATA;
    logic        S_AXIS_TLAST;
    logic        S_AXIS_TVALID;
    logic        S_AXIS_TREADY;
    logic [127:0] M_AXIS_TDATA;
    logic        M_AXIS_TVALID;
    logic        M_AXIS_TREADY;

    `include "tb_hdc_model.svh"

    hdc_top DUT (.*);

    always #10 AXIS_ACLK = ~AXIS_ACLK;

    // inputs change 1 ns after the edge
    task automatic next_cycle();
        @(posedge AXIS_ACLK);
        #1;
    endtask

    // ------------------------------
    // AXI-Lite access
    // ------------------------------
    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
        logic       ok;
        logic [1:0] resp;
        ok = 1'b0;
        resp = '0;
        S_AXI_AWADDR  = addr;
        S_AXI_WDATA   = data;
        S_AXI_AWVALID = 1'b1;
        S_AXI_WVALID  = 1'b1;
        for (int n = 0; n < wait_limit && !ok; n++) begin
            @(negedge AXIS_ACLK);
            ok = S_AXI_AWREADY & S_AXI_WREADY;
            next_cycle();
        end
        S_AXI_AWVALID = 1'b0;
        S_AXI_WVALID  = 1'b0;
        if (!ok) note_timeout("write address and data ready");
        ok = 1'b0;
        for (int n = 0; n < wait_limit && !ok; n++) begin
            @(negedge AXIS_ACLK);
            ok = S_AXI_BVALID;
            resp = S_AXI_BRESP;
            next_cycle();
        end
        if (!ok) begin
            note_timeout("write response");
        end else begin
            check_value("S_AXI_BRESP", out_word_t'(resp), out_word_t'(0));
        end
    endtask

    task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
        logic       ok;
        logic [1:0] resp;
        ok = 1'b0;
        resp = '0;
        data = '0;
        S_AXI_ARADDR  = addr;
        S_AXI_ARVALID = 1'b1;
        for (int n = 0; n < wait_limit && !ok; n++) begin
            @(negedge AXIS_ACLK);
            ok = S_AXI_ARREADY;
            next_cycle();
        end
        S_AXI_ARVALID = 1'b0;
        if (!ok) note_timeout("read address ready");
        ok = 1'b0;
        for (int n = 0; n < wait_limit && !ok; n++) begin
            @(negedge AXIS_ACLK);
            ok = S_AXI_RVALID;
            data = S_AXI_RDATA;
            resp = S_AXI_RRESP;
            next_cycle();
        end
        if (!ok) begin
            note_timeout("read data");
        end else begin
            check_value("S_AXI_RRESP", out_word_t'(resp), out_word_t'(0));
        end
    endtask

    // ------------------------------
    // streams
    // ------------------------------
    // valid stays high so that beats go back to back
    task automatic send_beat(input logic [31:0] data, input logic last);
        logic ok;
        ok = 1'b0;
        S_AXIS_TDATA  = data;
        S_AXIS_TLAST  = last;
        S_AXIS_TVALID = 1'b1;
        for (int n = 0; n < wait_limit && !ok; n++) begin
            @(negedge AXIS_ACLK);
            ok = S_AXIS_TREADY;
            next_cycle();
        end
        if (!ok) note_timeout("S_AXIS_TREADY");
        for (int c = 0; c < hdc_pkg::core_num; c++) begin
            accumulate(c, data[c*hdc_pkg::instr_w +: hdc_pkg::instr_w]);
        end
    endtask

    task automatic send_random_sequence(input int len);
        clear_counts();
        for (int b = 0; b < len; b++) begin
            send_beat($urandom, b == len - 1);
        end
        S_AXIS_TVALID = 1'b0;
    endtask

    task automatic get_result(output out_word_t data);
        logic ok;
        ok = 1'b0;
        data = '0;
        for (int n = 0; n < wait_limit && !ok; n++) begin
            @(negedge AXIS_ACLK);
            ok = M_AXIS_TVALID;
            data = M_AXIS_TDATA;
            next_cycle();
        end
        if (!ok) note_timeout("M_AXIS_TVALID");
    endtask

    task automatic expect_result();
        out_word_t got;
        get_result(got);
        check_value("M_AXIS_TDATA", got, expected_output());
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------
    task automatic register_access();
        logic [31:0] rd;
        write_reg(32'(axil_map_pkg::reg_count_off), 32'd5);
        read_reg(32'(axil_map_pkg::reg_count_off), rd);
        check_value("item_count", out_word_t'(rd), out_word_t'(5));
        read_reg(32'(axil_map_pkg::reg_ctrl_off), rd);
        check_value("mode", out_word_t'(rd), out_word_t'(0));
        read_reg(32'h0000_0008, rd);
        check_value("S_AXI_RDATA at 0x008", out_word_t'(rd), out_word_t'(0));
        // count offset with a decode bit set
        read_reg(32'h0000_0404, rd);
        check_value("S_AXI_RDATA at 0x404", out_word_t'(rd), out_word_t'(0));
    endtask

    task automatic generate_items();
        logic [31:0] rd;
        logic        done;
        done = 1'b0;
        write_reg(32'(axil_map_pkg::reg_count_off), 32'd16);
        write_reg(32'(axil_map_pkg::reg_ctrl_off), 32'(1 << axil_map_pkg::gen_bit));
        for (int n = 0; n < 40 && !done; n++) begin
            read_reg(32'(axil_map_pkg::reg_ctrl_off), rd);
            done = ~rd[axil_map_pkg::gen_bit];
        end
        if (!done) note_timeout("gen to clear");
        read_reg(32'(axil_map_pkg::reg_count_off), rd);
        check_value("item_count", out_word_t'(rd), out_word_t'(16));
    endtask

    task automatic single_item_encoding();
        out_word_t got;
        write_reg(32'(axil_map_pkg::reg_ctrl_off), 32'(1 << axil_map_pkg::run_bit));
        for (int k = 0; k < hdc_pkg::item_depth; k++) begin
            clear_counts();
            send_beat({2{hdc_pkg::instr_t'(k)}}, 1'b1);
            S_AXIS_TVALID = 1'b0;
            get_result(got);
            check_value("M_AXIS_TDATA", got, {item_table[k], item_table[k]});
        end
    endtask

    task automatic random_accumulation();
        for (int s = 0; s < 12; s++) begin
            send_random_sequence(int'($urandom_range(40, 1)));
            expect_result();
        end
    endtask

    task automatic back_pressure();
        out_word_t held;
        M_AXIS_TREADY = 1'b0;
        send_random_sequence(7);
        get_result(held);
        check_value("M_AXIS_TDATA", held, expected_output());
        for (int n = 0; n < 8; n++) begin
            @(negedge AXIS_ACLK);
            check_value("M_AXIS_TVALID", out_word_t'(M_AXIS_TVALID), out_word_t'(1));
            check_value("S_AXIS_TREADY", out_word_t'(S_AXIS_TREADY), out_word_t'(0));
            check_value("M_AXIS_TDATA", M_AXIS_TDATA, held);
            next_cycle();
        end
        M_AXIS_TREADY = 1'b1;
        next_cycle();
        send_random_sequence(int'($urandom_range(20, 2)));
        expect_result();
    endtask

    task automatic run_clear();
        logic [31:0] rd;
        clear_counts();
        for (int b = 0; b < 6; b++) begin
            send_beat($urandom, 1'b0);
        end
        S_AXIS_TVALID = 1'b0;
        write_reg(32'(axil_map_pkg::reg_ctrl_off), 32'd0);
        @(negedge AXIS_ACLK);
        check_value("S_AXIS_TREADY", out_word_t'(S_AXIS_TREADY), out_word_t'(0));
        next_cycle();
        read_reg(32'(axil_map_pkg::reg_ctrl_off), rd);
        check_value("mode", out_word_t'(rd), out_word_t'(0));
        write_reg(32'(axil_map_pkg::reg_ctrl_off), 32'(1 << axil_map_pkg::run_bit));
        send_random_sequence(9);
        expect_result();
    endtask

    initial begin
        void'($urandom(32'h015d4e06));
        checks        = 0;
        errors        = 0;
        timeouts      = 0;
        AXIS_ACLK     = 1'b0;
        S_AXI_ARESETN = 1'b0;
        S_AXI_AWADDR  = '0;
        S_AXI_AWVALID = 1'b0;
        S_AXI_WDATA   = '0;
        S_AXI_WVALID  = 1'b0;
        S_AXI_BREADY  = 1'b1;
        S_AXI_ARADDR  = '0;
        S_AXI_ARVALID = 1'b0;
        S_AXI_RREADY  = 1'b1;
        S_AXIS_TDATA  = '0;
        S_AXIS_TLAST  = 1'b0;
        S_AXIS_TVALID = 1'b0;
        M_AXIS_TREADY = 1'b1;
        build_items();
        repeat (4) @(posedge AXIS_ACLK);
        #1;
        S_AXI_ARESETN = 1'b1;

        register_access();
        generate_items();
        single_item_encoding();
        random_accumulation();
        back_pressure();
        run_clear();

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- source/hdc_top.sv
`timescale 1ns/1ps

module hdc_top (
    input  logic                                          AXIS_ACLK,
    input  logic                                          S_AXI_ARESETN,
    input  logic [31:0]                                   S_AXI_AWADDR,
    input  logic                                          S_AXI_AWVALID,
    output logic                                          S_AXI_AWREADY,
    input  logic [31:0]                                   S_AXI_WDATA,
    input  logic                                          S_AXI_WVALID,
    output logic                                          S_AXI_WREADY,
    output logic [1:0]                                    S_AXI_BRESP,
    output logic                                          S_AXI_BVALID,
    input  logic                                          S_AXI_BREADY,
    input  logic [31:0]                                   S_AXI_ARADDR,
    input  logic                                          S_AXI_ARVALID,
    output logic                                          S_AXI_ARREADY,
    output logic [31:0]                                   S_AXI_RDATA,
    output logic [1:0]                                    S_AXI_RRESP,
    output logic                                          S_AXI_RVALID,
    input  logic                                          S_AXI_RREADY,
    input  logic [hdc_pkg::core_num*hdc_pkg::instr_w-1:0] S_AXIS_TDATA,
    input  logic                                          S_AXIS_TLAST,
    input  logic                                          S_AXIS_TVALID,
    output logic                                          S_AXIS_TREADY,
    output logic [hdc_pkg::core_num*hdc_pkg::hv_dim-1:0]  M_AXIS_TDATA,
    output logic                                          M_AXIS_TVALID,
    input  logic                                          M_AXIS_TREADY
);

    logic                                gen;
    logic                                run;
    logic                                gen_done;
    logic [axil_map_pkg::count_w-1:0]    item_count;
    logic                                item_we;
    logic [hdc_pkg::item_addr_w-1:0]     item_waddr;
    hdc_pkg::hv_t                        item_wdata;

    // responses are always OKAY
    assign S_AXI_BRESP = 2'b00;
    assign S_AXI_RRESP = 2'b00;

    axil_ctrl u_ctrl (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .S_AXI_AWADDR  (S_AXI_AWADDR),
        .S_AXI_AWVALID (S_AXI_AWVALID),
        .S_AXI_AWREADY (S_AXI_AWREADY),
        .S_AXI_WDATA   (S_AXI_WDATA),
        .S_AXI_WVALID  (S_AXI_WVALID),
        .S_AXI_WREADY  (S_AXI_WREADY),
        .S_AXI_BVALID  (S_AXI_BVALID),
        .S_AXI_BREADY  (S_AXI_BREADY),
        .S_AXI_ARADDR  (S_AXI_ARADDR),
        .S_AXI_ARVALID (S_AXI_ARVALID),
        .S_AXI_ARREADY (S_AXI_ARREADY),
        .S_AXI_RDATA   (S_AXI_RDATA),
        .S_AXI_RVALID  (S_AXI_RVALID),
        .S_AXI_RREADY  (S_AXI_RREADY),
        .gen_done      (gen_done),
        .gen           (gen),
        .run           (run),
        .item_count    (item_count)
    );

    item_gen u_item_gen (
        .AXIS_ACLK  (AXIS_ACLK),
        .gen        (gen),
        .item_count (item_count),
        .item_we    (item_we),
        .item_waddr (item_waddr),
        .item_wdata (item_wdata),
        .gen_done   (gen_done)
    );

    // ------------------------------
    // encoder pipeline
    // ------------------------------
    encode_if enc ();

    stream_ctrl u_stream (
        .AXIS_ACLK     (AXIS_ACLK),
        .run           (run),
        .gen           (gen),
        .S_AXIS_TDATA  (S_AXIS_TDATA),
        .S_AXIS_TLAST  (S_AXIS_TLAST),
        .S_AXIS_TVALID (S_AXIS_TVALID),
        .S_AXIS_TREADY (S_AXIS_TREADY),
        .M_AXIS_TDATA  (M_AXIS_TDATA),
        .M_AXIS_TVALID (M_AXIS_TVALID),
        .M_AXIS_TREADY (M_AXIS_TREADY),
        .enc           (enc.ctrl)
    );

    // every core holds the same item table
    for (genvar i = 0; i < hdc_pkg::core_num; i++) begin : g_core
        hv_core #(
            .core_idx (i)
        ) u_core (
            .AXIS_ACLK  (AXIS_ACLK),
            .run        (run),
            .item_we    (item_we),
            .item_waddr (item_waddr),
            .item_wdata (item_wdata),
            .enc        (enc.core)
        );
    end

endmodule

//--- encoder/stream_ctrl.sv
`timescale 1ns/1ps

module stream_ctrl (
    input  logic                                          AXIS_ACLK,
    input  logic                                          run,
    input  logic                                          gen,
    input  logic [hdc_pkg::core_num*hdc_pkg::instr_w-1:0] S_AXIS_TDATA,
    input  logic                                          S_AXIS_TLAST,
    input  logic                                          S_AXIS_TVALID,
    output logic                                          S_AXIS_TREADY,
    output logic [hdc_pkg::core_num*hdc_pkg::hv_dim-1:0]  M_AXIS_TDATA,
    output logic                                          M_AXIS_TVALID,
    input  logic                                          M_AXIS_TREADY,
    encode_if.ctrl                                        enc
);

    logic s1_valid;
    logic s1_last;
    logic pending;
    logic out_fire;

    // input stalls from a last beat until its result has left
    assign S_AXIS_TREADY = run & ~gen & ~pending;
    assign enc.beat_take = S_AXIS_TVALID & S_AXIS_TREADY;
    assign enc.instr     = S_AXIS_TDATA;

    assign out_fire     = M_AXIS_TVALID & M_AXIS_TREADY;
    assign M_AXIS_TDATA = enc.result;

    // ------------------------------
    // stage flags and output hold
    // ------------------------------
    always_ff @(posedge AXIS_ACLK) begin
        if (!run) begin
            s1_valid      <= 1'b0;
            s1_last       <= 1'b0;
            enc.acc_en    <= 1'b0;
            enc.acc_last  <= 1'b0;
            pending       <= 1'b0;
            M_AXIS_TVALID <= 1'b0;
        end else begin
            s1_valid     <= enc.beat_take;
            s1_last      <= enc.beat_take & S_AXIS_TLAST;
            enc.acc_en   <= s1_valid;
            enc.acc_last <= s1_last;

            if (enc.beat_take && S_AXIS_TLAST) begin
                pending <= 1'b1;
            end else if (out_fire) begin
                pending <= 1'b0;
            end

            // result register loads on the same edge
            if (enc.acc_en && enc.acc_last) begin
                M_AXIS_TVALID <= 1'b1;
            end else if (out_fire) begin
                M_AXIS_TVALID <= 1'b0;
            end
        end
    end

endmodule

//--- encoder/hv_core.sv
`timescale 1ns/1ps

module hv_core #(
    parameter int core_idx = 0
) (
    input  logic                            AXIS_ACLK,
    input  logic                            run,
    input  logic                            item_we,
    input  logic [hdc_pkg::item_addr_w-1:0] item_waddr,
    input  hdc_pkg::hv_t                    item_wdata,
    encode_if.core                          enc
);

    hdc_pkg::hv_t                   item_mem [hdc_pkg::item_depth];
    hdc_pkg::instr_t                instr_q;
    logic [hdc_pkg::rot_w-1:0]      rot;
    logic [2*hdc_pkg::hv_dim-1:0]   rot_dbl;
    hdc_pkg::hv_t                   vec_q;
    hdc_pkg::cnt_t                  cnt     [hdc_pkg::hv_dim];
    hdc_pkg::cnt_t                  cnt_nxt [hdc_pkg::hv_dim];
    hdc_pkg::hv_t                   sign_nxt;
    hdc_pkg::hv_t                   res_q;

    always_ff @(posedge AXIS_ACLK) begin
        if (item_we) begin
            item_mem[item_waddr] <= item_wdata;
        end
    end

    // ------------------------------
    // stage 0, instruction
    // ------------------------------
    always_ff @(posedge AXIS_ACLK) begin
        if (enc.beat_take) begin
            instr_q <= enc.instr[core_idx];
        end
    end

    // ------------------------------
    // stage 1, read and rotate
    // ------------------------------
    // bit j of the result takes bit (j - rot) mod 64
    assign rot     = instr_q[hdc_pkg::rot_lsb +: hdc_pkg::rot_w];
    assign rot_dbl = {item_mem[instr_q[hdc_pkg::item_addr_w-1:0]],
                      item_mem[instr_q[hdc_pkg::item_addr_w-1:0]]} << rot;

    always_ff @(posedge AXIS_ACLK) begin
        vec_q <= rot_dbl[2*hdc_pkg::hv_dim-1:hdc_pkg::hv_dim];
    end

    // ------------------------------
    // stage 2, accumulate
    // ------------------------------
    always_comb begin
        for (int j = 0; j < hdc_pkg::hv_dim; j++) begin
            if (vec_q[j]) begin
                cnt_nxt[j] = cnt[j] + hdc_pkg::cnt_t'(1);
            end else begin
                cnt_nxt[j] = cnt[j] - hdc_pkg::cnt_t'(1);
            end
            sign_nxt[j] = (cnt_nxt[j] > 0);
        end
    end

    // last beat stores the signs and starts a fresh sum
    always_ff @(posedge AXIS_ACLK) begin
        if (!run) begin
            cnt <= '{default: '0};
        end else if (enc.acc_en && enc.acc_last) begin
            cnt <= '{default: '0};
        end else if (enc.acc_en) begin
            cnt <= cnt_nxt;
        end
    end

    always_ff @(posedge AXIS_ACLK) begin
        if (run && enc.acc_en && enc.acc_last) begin
            res_q <= sign_nxt;
        end
    end

    assign enc.result[core_idx] = res_q;

endmodule

//--- itemgen/item_gen.sv
`timescale 1ns/1ps

module item_gen (
    input  logic                                AXIS_ACLK,
    input  logic                                gen,
    input  logic [axil_map_pkg::count_w-1:0]    item_count,
    output logic                                item_we,
    output logic [hdc_pkg::item_addr_w-1:0]     item_waddr,
    output hdc_pkg::hv_t                        item_wdata,
    output logic                                gen_done
);

    logic [hdc_pkg::word_w-1:0]                  rand_word;
    logic                                        armed;
    logic [$clog2(hdc_pkg::words_per_hv)-1:0]    word_sel;
    logic [axil_map_pkg::count_w-1:0]            item_idx;
    hdc_pkg::hv_t                                hv_q;
    logic                                        last_word;

    xorshift32 prng (
        .AXIS_ACLK (AXIS_ACLK),
        .gen       (gen),
        .rand_word (rand_word)
    );

    // first gen cycle still shows the seed, so skip it
    always_ff @(posedge AXIS_ACLK) begin
        if (!gen) begin
            armed    <= 1'b0;
            word_sel <= '0;
            item_idx <= '0;
        end else begin
            armed <= 1'b1;
            if (armed && last_word) begin
                word_sel <= '0;
                item_idx <= item_idx + 1'b1;
            end else if (armed) begin
                word_sel <= word_sel + 1'b1;
            end
        end
    end

    // word k lands in bits 32k+31..32k
    always_ff @(posedge AXIS_ACLK) begin
        if (armed) begin
            hv_q[word_sel*hdc_pkg::word_w +: hdc_pkg::word_w] <= rand_word;
        end
    end

    // top word goes straight from the generator into the memories
    always_comb begin
        item_wdata = hv_q;
        item_wdata[word_sel*hdc_pkg::word_w +: hdc_pkg::word_w] = rand_word;
    end

    assign last_word  = (int'(word_sel) == hdc_pkg::words_per_hv - 1);
    assign item_we    = gen & armed & last_word;
    assign item_waddr = item_idx[hdc_pkg::item_addr_w-1:0];

    // zero items means done at once
    assign gen_done = gen & ((item_count == '0) |
                             (item_we & (item_idx == item_count - 1'b1)));

endmodule

//--- itemgen/xorshift32.sv
`timescale 1ns/1ps

module xorshift32 (
    input  logic                       AXIS_ACLK,
    input  logic                       gen,
    output logic [hdc_pkg::word_w-1:0] rand_word
);

    logic [hdc_pkg::word_w-1:0] step_a;
    logic [hdc_pkg::word_w-1:0] step_b;
    logic [hdc_pkg::word_w-1:0] step_c;

    // 13/17/5 shift-xor chain
    always_comb begin
        step_a = rand_word ^ (rand_word << 13);
        step_b = step_a ^ (step_a >> 17);
        step_c = step_b ^ (step_b << 5);
    end

    // sits on the seed until gen rises
    always_ff @(posedge AXIS_ACLK) begin
        if (!gen) begin
            rand_word <= hdc_pkg::xs_seed;
        end else begin
            rand_word <= step_c;
        end
    end

endmodule

//--- control/axil_ctrl.sv
`timescale 1ns/1ps

module axil_ctrl (
    input  logic                             AXIS_ACLK,
    input  logic                             S_AXI_ARESETN,
    input  logic [31:0]                      S_AXI_AWADDR,
    input  logic                             S_AXI_AWVALID,
    output logic                             S_AXI_AWREADY,
    input  logic [31:0]                      S_AXI_WDATA,
    input  logic                             S_AXI_WVALID,
    output logic                             S_AXI_WREADY,
    output logic                             S_AXI_BVALID,
    input  logic                             S_AXI_BREADY,
    input  logic [31:0]                      S_AXI_ARADDR,
    input  logic                             S_AXI_ARVALID,
    output logic                             S_AXI_ARREADY,
    output logic [31:0]                      S_AXI_RDATA,
    output logic                             S_AXI_RVALID,
    input  logic                             S_AXI_RREADY,
    input  logic                             gen_done,
    output logic                             gen,
    output logic                             run,
    output logic [axil_map_pkg::count_w-1:0] item_count
);

    logic [2:0]                                                  state;
    logic [axil_map_pkg::decode_hi+1:axil_map_pkg::addr_lsb]     waddr_q;
    logic [axil_map_pkg::decode_hi+1:axil_map_pkg::addr_lsb]     raddr_q;
    logic [31:0]                                                 wdata_q;
    logic [axil_map_pkg::decode_hi-1:0]                          woff;
    logic [axil_map_pkg::decode_hi-1:0]                          roff;
    logic                                                        wr_ctrl;
    logic                                                        wr_count;
    logic                                                        rd_hit;
    logic [31:0]                                                 rd_word;

    // a read is only taken when no write is offered
    assign S_AXI_AWREADY = (state == axil_map_pkg::st_idle) | (state == axil_map_pkg::st_data);
    assign S_AXI_WREADY  = (state == axil_map_pkg::st_idle) | (state == axil_map_pkg::st_addr);
    assign S_AXI_ARREADY = (state == axil_map_pkg::st_idle) & ~S_AXI_AWVALID & ~S_AXI_WVALID;
    assign S_AXI_BVALID  = (state == axil_map_pkg::st_both);
    assign S_AXI_RVALID  = (state == axil_map_pkg::st_rdata);

    // ------------------------------
    // channel FSM
    // ------------------------------
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= axil_map_pkg::st_idle;
        end else begin
            case (state)
                axil_map_pkg::st_idle: begin
                    if (S_AXI_AWVALID & S_AXI_WVALID) begin
                        state <= axil_map_pkg::st_both;
                    end else if (S_AXI_AWVALID) begin
                        state <= axil_map_pkg::st_addr;
                    end else if (S_AXI_WVALID) begin
                        state <= axil_map_pkg::st_data;
                    end else if (S_AXI_ARVALID) begin
                        state <= axil_map_pkg::st_rwait;
                    end
                end
                axil_map_pkg::st_addr: if (S_AXI_WVALID) state <= axil_map_pkg::st_both;
                axil_map_pkg::st_data: if (S_AXI_AWVALID) state <= axil_map_pkg::st_both;
                axil_map_pkg::st_both: if (S_AXI_BREADY) state <= axil_map_pkg::st_idle;
                axil_map_pkg::st_rwait: state <= axil_map_pkg::st_rdata;
                axil_map_pkg::st_rdata: if (S_AXI_RREADY) state <= axil_map_pkg::st_idle;
                default: state <= axil_map_pkg::st_idle;
            endcase
        end
    end

    // address and data latches
    always_ff @(posedge AXIS_ACLK) begin
        if (S_AXI_AWVALID & S_AXI_AWREADY) begin
            waddr_q <= S_AXI_AWADDR[axil_map_pkg::decode_hi+1:axil_map_pkg::addr_lsb];
        end
        if (S_AXI_WVALID & S_AXI_WREADY) begin
            wdata_q <= S_AXI_WDATA;
        end
        if (S_AXI_ARVALID & S_AXI_ARREADY) begin
            raddr_q <= S_AXI_ARADDR[axil_map_pkg::decode_hi+1:axil_map_pkg::addr_lsb];
        end
        if (state == axil_map_pkg::st_rwait) begin
            S_AXI_RDATA <= rd_word;
        end
    end

    // ------------------------------
    // register decode
    // ------------------------------
    assign woff = {waddr_q[axil_map_pkg::decode_hi-1:axil_map_pkg::addr_lsb],
                   {axil_map_pkg::addr_lsb{1'b0}}};
    assign roff = {raddr_q[axil_map_pkg::decode_hi-1:axil_map_pkg::addr_lsb],
                   {axil_map_pkg::addr_lsb{1'b0}}};

    // write takes effect once, when the response is accepted
    assign wr_ctrl  = (state == axil_map_pkg::st_both) & S_AXI_BREADY &
                      (waddr_q[axil_map_pkg::decode_hi+1:axil_map_pkg::decode_hi] == 2'b00) &
                      (woff == axil_map_pkg::reg_ctrl_off);
    assign wr_count = (state == axil_map_pkg::st_both) & S_AXI_BREADY &
                      (waddr_q[axil_map_pkg::decode_hi+1:axil_map_pkg::decode_hi] == 2'b00) &
                      (woff == axil_map_pkg::reg_count_off);
    assign rd_hit   = (raddr_q[axil_map_pkg::decode_hi+1:axil_map_pkg::decode_hi] == 2'b00);

    // unmapped offsets read back as zero
    always_comb begin
        rd_word = '0;
        if (rd_hit && roff == axil_map_pkg::reg_ctrl_off) begin
            rd_word[axil_map_pkg::gen_bit] = gen;
            rd_word[axil_map_pkg::run_bit] = run;
        end else if (rd_hit && roff == axil_map_pkg::reg_count_off) begin
            rd_word[axil_map_pkg::count_w-1:0] = item_count;
        end
    end

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            gen        <= 1'b0;
            run        <= 1'b0;
            item_count <= '0;
        end else begin
            if (wr_ctrl) begin
                gen <= wdata_q[axil_map_pkg::gen_bit];
                run <= wdata_q[axil_map_pkg::run_bit];
            end else if (gen_done) begin
                gen <= 1'b0;
            end
            if (wr_count) begin
                item_count <= wdata_q[axil_map_pkg::count_w-1:0];
            end
        end
    end

endmodule

//--- common/encode_if.sv
`timescale 1ns/1ps

interface encode_if;

    // input beat accepted this cycle, all cores' instructions
    logic                                    beat_take;
    hdc_pkg::instr_t [hdc_pkg::core_num-1:0] instr;

    // stage-2 flags
    logic acc_en;
    logic acc_last;

    // sign vectors, each core drives its own slice
    wire hdc_pkg::hv_t [hdc_pkg::core_num-1:0] result;

    modport ctrl (
        output beat_take, output instr, output acc_en, output acc_last,
        input  result
    );

    modport core (
        input  beat_take, input instr, input acc_en, input acc_last,
        output result
    );

endinterface

//--- common/axil_map_pkg.sv
package axil_map_pkg;

    // register window, bits 11..10 of the address must be zero
    localparam int decode_hi = 10;
    localparam int addr_lsb  = 2;

    localparam logic [decode_hi-1:0] reg_ctrl_off  = 10'h000;
    localparam logic [decode_hi-1:0] reg_count_off = 10'h004;

    // mode register bits and item count width
    localparam int gen_bit = 0;
    localparam int run_bit = 1;
    localparam int count_w = 5;

    // write/read channel FSM states
    localparam logic [2:0] st_idle  = 3'd0;
    localparam logic [2:0] st_addr  = 3'd1;
    localparam logic [2:0] st_data  = 3'd2;
    localparam logic [2:0] st_both  = 3'd3;
    localparam logic [2:0] st_rwait = 3'd4;
    localparam logic [2:0] st_rdata = 3'd5;

endpackage

//--- common/hdc_pkg.sv
package hdc_pkg;

    // hypervector and generator word sizes
    localparam int hv_dim       = 64;
    localparam int word_w       = 32;
    localparam int words_per_hv = hv_dim / word_w;

    // core array and item memory
    localparam int core_num    = 2;
    localparam int item_depth  = 16;
    localparam int item_addr_w = $clog2(item_depth);

    // instruction word, rotate on top and item index below
    localparam int instr_w = 16;
    localparam int rot_lsb = 10;
    localparam int rot_w   = 6;
    localparam int addr_w  = 10;

    // signed per-bit accumulator
    localparam int cnt_w = 8;

    localparam logic [word_w-1:0] xs_seed = 32'h2545F491;

    typedef logic [hv_dim-1:0]       hv_t;
    typedef logic [instr_w-1:0]      instr_t;
    typedef logic signed [cnt_w-1:0] cnt_t;

endpackage
